/* include/ninjin_params.svh */
`ifndef NINJIN_PARAMS_SVH
`define NINJIN_PARAMS_SVH

// Datapath widths
`define DWIDTH  16
`define WWIDTH  8
`define LWIDTH  10

// Memory address widths
`define IMGSIZE 10
`define NETSIZE 12

// Wishbone word address and data
`define WB_AW   16
`define WB_DW   32

// Top two address bits select the region
`define REGION_REG 0
`define REGION_IMG 1
`define REGION_NET 2

`define REG_WHICH      0
`define REG_REQ        1
`define REG_IN_OFFSET  2
`define REG_OUT_OFFSET 3
`define REG_NET_OFFSET 4
`define REG_TOTAL_OUT  5
`define REG_TOTAL_IN   6
`define REG_STATUS     15

`endif

/* verilog/ninjin_pkg.sv */
`include "ninjin_params.svh"

package ninjin_pkg;

  typedef logic signed [`DWIDTH-1:0] img_word_t;
  typedef logic signed [`WWIDTH-1:0] weight_t;
  typedef logic [`IMGSIZE-1:0]       img_addr_t;
  typedef logic [`NETSIZE-1:0]       net_addr_t;
  typedef logic [`LWIDTH-1:0]        len_t;
  typedef logic signed [31:0]        acc_t;

  // Owner of the image and weight memories
  typedef enum logic [1:0] {
    WHICH_HOST     = 2'd0,
    WHICH_GOBOU    = 2'd1,
    WHICH_RESERVED = 2'd2
  } which_t;

  typedef struct packed {
    img_addr_t in_offset;
    img_addr_t out_offset;
    net_addr_t net_offset;
    len_t      total_out;
    len_t      total_in;
  } fc_cfg_t;

  typedef struct packed {
    logic      we;
    img_addr_t addr;
    img_word_t wdata;
  } img_req_t;

  typedef struct packed {
    logic      we;
    net_addr_t addr;
    weight_t   wdata;
  } net_req_t;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`WB_AW-1:0] adr;
    logic [`WB_DW-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [`WB_DW-1:0] dat_r;
  } wb_rsp_t;

endpackage

/* verilog/mem_sp.sv */
`timescale 1ns/100ps

module mem_sp #(
  parameter type word_t = logic [7:0],
  parameter int  ADDR_W = 10
) (
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  word_t             wdata,
  output word_t             rdata
);

  word_t mem [2**ADDR_W];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

/* verilog/ninjin_ctrl.sv */
`timescale 1ns/100ps
`include "ninjin_params.svh"

module ninjin_ctrl (
  input  logic                  clk,
  input  logic                  xrst,
  input  ninjin_pkg::wb_req_t   wb_req,
  output ninjin_pkg::wb_rsp_t   wb_rsp,
  output ninjin_pkg::fc_cfg_t   cfg,
  output logic                  start,
  input  logic                  done,
  input  ninjin_pkg::img_req_t  fc_img_req,
  input  ninjin_pkg::net_addr_t fc_net_addr,
  output ninjin_pkg::img_req_t  img_req,
  input  ninjin_pkg::img_word_t img_rdata,
  output ninjin_pkg::net_req_t  net_req
);
  import ninjin_pkg::*;

  logic              access;
  logic              ack;
  logic [1:0]        region;
  logic [3:0]        index;
  logic [1:0]        rd_region;
  logic [3:0]        rd_index;
  which_t            which;
  logic              req;
  logic              req_d;
  logic              host_img_we;
  logic              host_net_we;
  logic              status_ack;
  logic [`WB_DW-1:0] reg_rdata;
  logic [`WB_DW-1:0] rd_data;

  // New access only when no ack is pending
  assign access = wb_req.cyc & wb_req.stb & ~ack;
  assign region = wb_req.adr[`WB_AW-1 -: 2];
  assign index  = wb_req.adr[3:0];

  assign host_img_we = access & wb_req.we & (region == `REGION_IMG);
  assign host_net_we = access & wb_req.we & (region == `REGION_NET);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack   <= 1'b0;
      which <= WHICH_HOST;
      req   <= 1'b0;
      req_d <= 1'b0;
      start <= 1'b0;
      cfg   <= '0;
    end else begin
      ack   <= access;
      req_d <= req;
      start <= req & ~req_d & (which == WHICH_GOBOU);
      if (access && wb_req.we && region == `REGION_REG) begin
        case (index)
          `REG_WHICH:      which          <= which_t'(wb_req.dat_w[1:0]);
          `REG_REQ:        req            <= wb_req.dat_w[0];
          `REG_IN_OFFSET:  cfg.in_offset  <= img_addr_t'(wb_req.dat_w);
          `REG_OUT_OFFSET: cfg.out_offset <= img_addr_t'(wb_req.dat_w);
          `REG_NET_OFFSET: cfg.net_offset <= net_addr_t'(wb_req.dat_w);
          `REG_TOTAL_OUT:  cfg.total_out  <= len_t'(wb_req.dat_w);
          `REG_TOTAL_IN:   cfg.total_in   <= len_t'(wb_req.dat_w);
          default: ;
        endcase
      end
    end
  end

  // Decode kept for the read data phase
  always_ff @(posedge clk) begin
    if (access) begin
      rd_region <= region;
      rd_index  <= index;
    end
  end

  always_comb begin
    case (which)
      WHICH_HOST:     status_ack = 1'b1;
      WHICH_GOBOU:    status_ack = done;
      WHICH_RESERVED: status_ack = 1'b0;
      default:        status_ack = 1'b0;
    endcase
  end

  always_comb begin
    reg_rdata = '0;
    case (rd_index)
      `REG_WHICH:      reg_rdata = `WB_DW'(which);
      `REG_REQ:        reg_rdata = `WB_DW'(req);
      `REG_IN_OFFSET:  reg_rdata = `WB_DW'(cfg.in_offset);
      `REG_OUT_OFFSET: reg_rdata = `WB_DW'(cfg.out_offset);
      `REG_NET_OFFSET: reg_rdata = `WB_DW'(cfg.net_offset);
      `REG_TOTAL_OUT:  reg_rdata = `WB_DW'(cfg.total_out);
      `REG_TOTAL_IN:   reg_rdata = `WB_DW'(cfg.total_in);
      `REG_STATUS:     reg_rdata = `WB_DW'(status_ack);
      default: ;
    endcase
  end

  // Weight region reads back as zero
  always_comb begin
    rd_data = '0;
    if (rd_region == `REGION_REG) begin
      rd_data = reg_rdata;
    end else if (rd_region == `REGION_IMG && which == WHICH_HOST) begin
      rd_data = {{(`WB_DW-`DWIDTH){img_rdata[`DWIDTH-1]}}, img_rdata};
    end
  end

  assign wb_rsp = '{ack: ack, dat_r: rd_data};

  // Memory ownership
  always_comb begin
    img_req = '0;
    net_req = '0;
    case (which)
      WHICH_HOST: begin
        img_req.we    = host_img_we;
        img_req.addr  = img_addr_t'(wb_req.adr);
        img_req.wdata = img_word_t'(wb_req.dat_w);
        net_req.we    = host_net_we;
        net_req.addr  = net_addr_t'(wb_req.adr);
        net_req.wdata = weight_t'(wb_req.dat_w);
      end
      WHICH_GOBOU: begin
        img_req      = fc_img_req;
        net_req.addr = fc_net_addr;
      end
      default: ;
    endcase
  end

  assert property (@(posedge clk) disable iff (!xrst)
                   which inside {WHICH_HOST, WHICH_GOBOU, WHICH_RESERVED})
    else $error("Undefined memory owner selected");

endmodule

/* verilog/gobou_fc.sv */
`timescale 1ns/100ps

module gobou_fc (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  start,
  input  ninjin_pkg::fc_cfg_t   cfg,
  output ninjin_pkg::img_req_t  img_req,
  input  ninjin_pkg::img_word_t img_rdata,
  output ninjin_pkg::net_addr_t net_addr,
  input  ninjin_pkg::weight_t   net_rdata,
  output logic                  done
);
  import ninjin_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_DRAIN,
    S_WRITE
  } state_t;

  localparam acc_t SAT_MAX = acc_t'(2**($bits(img_word_t) - 1) - 1);

  state_t    state;
  len_t      in_cnt;
  len_t      out_cnt;
  net_addr_t row_base;
  logic      last_in;
  logic      last_out;
  logic      v1;
  logic      v2;
  logic      last1;
  logic      last2;
  acc_t      prod;
  acc_t      acc;
  img_word_t result;

  assign last_in  = in_cnt == cfg.total_in - len_t'(1);
  assign last_out = out_cnt == cfg.total_out - len_t'(1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_IDLE;
      v1    <= 1'b0;
      v2    <= 1'b0;
    end else begin
      // Memory data is one cycle behind the address, product one more
      v1 <= state == S_READ;
      v2 <= v1;
      case (state)
        S_IDLE:  if (start) state <= S_READ;
        S_READ:  if (last_in) state <= S_DRAIN;
        S_DRAIN: if (v2 && last2) state <= S_WRITE;
        S_WRITE: state <= last_out ? S_IDLE : S_READ;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    last1 <= last_in;
    last2 <= last1;
    prod  <= img_rdata * net_rdata;
    if (state == S_IDLE && start) begin
      in_cnt   <= '0;
      out_cnt  <= '0;
      row_base <= cfg.net_offset;
      acc      <= '0;
    end else if (state == S_READ) begin
      in_cnt <= in_cnt + len_t'(1);
    end else if (state == S_WRITE) begin
      in_cnt   <= '0;
      out_cnt  <= out_cnt + len_t'(1);
      row_base <= row_base + net_addr_t'(cfg.total_in);
      acc      <= '0;
    end
    if (v2) begin
      acc <= acc + prod;
    end
  end

  // ReLU with saturation to the image word
  always_comb begin
    if (acc < 0) begin
      result = '0;
    end else if (acc > SAT_MAX) begin
      result = img_word_t'(SAT_MAX);
    end else begin
      result = img_word_t'(acc);
    end
  end

  assign img_req = '{
    we:    state == S_WRITE,
    addr:  (state == S_WRITE) ? cfg.out_offset + out_cnt : cfg.in_offset + in_cnt,
    wdata: result
  };

  assign net_addr = row_base + net_addr_t'(in_cnt);
  assign done     = state == S_IDLE;

  assert property (@(posedge clk) disable iff (!xrst) img_req.we |-> out_cnt < cfg.total_out)
    else $error("Image write past the last output");

endmodule

/* verilog/kinpira_top.sv */
`timescale 1ns/100ps
`include "ninjin_params.svh"

module kinpira_top (
  input  logic                clk,
  input  logic                xrst,
  input  ninjin_pkg::wb_req_t wb_req,
  output ninjin_pkg::wb_rsp_t wb_rsp
);
  import ninjin_pkg::*;

  fc_cfg_t   cfg;
  logic      start;
  logic      done;
  img_req_t  fc_img_req;
  net_addr_t fc_net_addr;
  img_req_t  img_req;
  img_word_t img_rdata;
  net_req_t  net_req;
  weight_t   net_rdata;

  ninjin_ctrl u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .cfg         (cfg),
    .start       (start),
    .done        (done),
    .fc_img_req  (fc_img_req),
    .fc_net_addr (fc_net_addr),
    .img_req     (img_req),
    .img_rdata   (img_rdata),
    .net_req     (net_req)
  );

  gobou_fc u_fc (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .cfg       (cfg),
    .img_req   (fc_img_req),
    .img_rdata (img_rdata),
    .net_addr  (fc_net_addr),
    .net_rdata (net_rdata),
    .done      (done)
  );

  mem_sp #(
    .word_t (img_word_t),
    .ADDR_W (`IMGSIZE)
  ) mem_img (
    .clk   (clk),
    .we    (img_req.we),
    .addr  (img_req.addr),
    .wdata (img_req.wdata),
    .rdata (img_rdata)
  );

  mem_sp #(
    .word_t (weight_t),
    .ADDR_W (`NETSIZE)
  ) mem_net (
    .clk   (clk),
    .we    (net_req.we),
    .addr  (net_req.addr),
    .wdata (net_req.wdata),
    .rdata (net_rdata)
  );

endmodule

/* verif/tb_kinpira.sv */
`timescale 1ns/100ps
`include "ninjin_params.svh"

module tb_kinpira;
  import ninjin_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int ACK_LIMIT  = 8;
  // Bus accesses take about three cycles, four is the upper bound
  localparam int MAX_ACCESSES    = 400;
  localparam int POLL_BOUND      = 3 * (5 + 4) + 20;
  localparam int WATCHDOG_CYCLES = MAX_ACCESSES * 4 + 3 * POLL_BOUND + 200;

  logic        clk;
  logic        xrst;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  int          n_checks;
  int          n_errors;
  int          cycle;
  logic [31:0] rng;
  img_word_t   img_data [8];
  img_word_t   in_vec [16];
  weight_t     wt [64];
  img_addr_t   kept_addr [$];
  img_word_t   kept_val [$];

  kinpira_top dut_i (
    .clk    (clk),
    .xrst   (xrst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [`WB_AW-1:0] reg_adr(input int idx);
    return {2'(`REGION_REG), {(`WB_AW-6){1'b0}}, 4'(idx)};
  endfunction

  function automatic logic [`WB_AW-1:0] img_adr(input img_addr_t a);
    return {2'(`REGION_IMG), {(`WB_AW-2-`IMGSIZE){1'b0}}, a};
  endfunction

  function automatic logic [`WB_AW-1:0] net_adr(input net_addr_t a);
    return {2'(`REGION_NET), {(`WB_AW-2-`NETSIZE){1'b0}}, a};
  endfunction

  // ReLU, then clamp to the largest image word
  function automatic img_word_t relu_sat(input int sum);
    if (sum < 0) return img_word_t'(0);
    if (sum > 32767) return img_word_t'(32767);
    return img_word_t'(sum);
  endfunction

  function automatic logic [31:0] field_mask(input int idx);
    case (idx)
      `REG_NET_OFFSET: return (32'd1 << `NETSIZE) - 1;
      `REG_TOTAL_OUT, `REG_TOTAL_IN: return (32'd1 << `LWIDTH) - 1;
      default: return (32'd1 << `IMGSIZE) - 1;
    endcase
  endfunction

  task automatic check_word(input string what, input logic [`WB_DW-1:0] got,
                            input logic [`WB_DW-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_img(input string what, input img_word_t got, input img_word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // One classic cycle, then make sure ack drops again
  task automatic wb_access(input logic we, input logic [`WB_AW-1:0] adr,
                           input logic [`WB_DW-1:0] dat, output logic [`WB_DW-1:0] rdata);
    int n;
    @(posedge clk);
    #DRIVE_DLY;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!wb_rsp.ack && n < ACK_LIMIT);
    rdata = wb_rsp.dat_r;
    if (!wb_rsp.ack) begin
      n_errors++;
      $display("No Wishbone ack for address %h at %0t ns", adr, $time);
    end
    #(DRIVE_DLY - 1);
    wb_req = '0;
    @(posedge clk);
    #1;
    if (wb_rsp.ack) begin
      n_errors++;
      $display("Wishbone ack stayed high for address %h at %0t ns", adr, $time);
    end
  endtask

  task automatic wb_write(input logic [`WB_AW-1:0] adr, input logic [`WB_DW-1:0] dat);
    logic [`WB_DW-1:0] unused_rd;
    wb_access(1'b1, adr, dat, unused_rd);
  endtask

  task automatic wb_read(input logic [`WB_AW-1:0] adr, output logic [`WB_DW-1:0] data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic test_registers();
    logic [31:0] vals [7];
    logic [31:0] rd;
    for (int idx = `REG_IN_OFFSET; idx <= `REG_TOTAL_IN; idx++) begin
      rng = xorshift32(rng);
      vals[idx] = rng;
      wb_write(reg_adr(idx), rng);
    end
    for (int idx = `REG_IN_OFFSET; idx <= `REG_TOTAL_IN; idx++) begin
      wb_read(reg_adr(idx), rd);
      check_word($sformatf("register %0d", idx), rd, vals[idx] & field_mask(idx));
    end
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_RESERVED));
    wb_read(reg_adr(`REG_WHICH), rd);
    check_word("which register", rd, 32'd2);
    wb_write(reg_adr(`REG_REQ), 32'hffff_ffff);
    wb_read(reg_adr(`REG_REQ), rd);
    check_word("req register", rd, 32'd1);
    wb_write(reg_adr(`REG_REQ), 32'd0);
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_HOST));
  endtask

  task automatic test_image();
    logic [31:0] rd;
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_HOST));
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      img_data[i] = img_word_t'(rng[15:0]);
      wb_write(img_adr(img_addr_t'(100 + i)), rng);
    end
    for (int i = 0; i < 8; i++) begin
      wb_read(img_adr(img_addr_t'(100 + i)), rd);
      check_word($sformatf("image word %0d", 100 + i), rd, 32'(img_data[i]));
    end
  endtask

  task automatic test_ownership();
    logic [31:0] rd;
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_GOBOU));
    wb_write(img_adr(100), 32'h0000_5a5a);
    wb_read(img_adr(100), rd);
    check_word("image read under GOBOU", rd, 32'd0);
    wb_read(reg_adr(`REG_STATUS), rd);
    check_word("status of idle engine", rd, 32'd1);
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_RESERVED));
    wb_read(reg_adr(`REG_STATUS), rd);
    check_word("status under RESERVED", rd, 32'd0);
    wb_read(img_adr(101), rd);
    check_word("image read under RESERVED", rd, 32'd0);
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_HOST));
    wb_read(reg_adr(`REG_STATUS), rd);
    check_word("status under HOST", rd, 32'd1);
    for (int i = 0; i < 8; i++) begin
      wb_read(img_adr(img_addr_t'(100 + i)), rd);
      check_img($sformatf("image word %0d after GOBOU", 100 + i), img_word_t'(rd[15:0]),
                img_data[i]);
    end
  endtask

  // Load in_vec and wt, run the engine, compare against the dot products
  task automatic run_fc(input img_addr_t in_off, input img_addr_t out_off,
                        input net_addr_t net_off, input int n_out, input int n_in);
    logic [31:0] rd;
    int          t0;
    int          limit;
    int          sum;
    img_word_t   exp;
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_HOST));
    wb_write(reg_adr(`REG_REQ), 32'd0);
    for (int i = 0; i < n_in; i++) begin
      wb_write(img_adr(in_off + img_addr_t'(i)), 32'(in_vec[i]));
    end
    for (int j = 0; j < n_in * n_out; j++) begin
      wb_write(net_adr(net_off + net_addr_t'(j)), 32'(wt[j]));
    end
    wb_write(reg_adr(`REG_IN_OFFSET), 32'(in_off));
    wb_write(reg_adr(`REG_OUT_OFFSET), 32'(out_off));
    wb_write(reg_adr(`REG_NET_OFFSET), 32'(net_off));
    wb_write(reg_adr(`REG_TOTAL_OUT), 32'(n_out));
    wb_write(reg_adr(`REG_TOTAL_IN), 32'(n_in));
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_GOBOU));
    wb_write(reg_adr(`REG_REQ), 32'd1);
    limit = n_out * (n_in + 4) + 20;
    t0 = cycle;
    rd = '0;
    while (rd[0] !== 1'b1 && cycle - t0 < limit) begin
      wb_read(reg_adr(`REG_STATUS), rd);
    end
    if (rd[0] !== 1'b1) begin
      n_errors++;
      $display("Engine still busy after %0d cycles at %0t ns", limit, $time);
    end
    wb_write(reg_adr(`REG_WHICH), 32'(WHICH_HOST));
    for (int o = 0; o < n_out; o++) begin
      sum = 0;
      for (int i = 0; i < n_in; i++) begin
        sum += int'(in_vec[i]) * int'(wt[o * n_in + i]);
      end
      exp = relu_sat(sum);
      wb_read(img_adr(out_off + img_addr_t'(o)), rd);
      check_img($sformatf("output at %0d", out_off + o), img_word_t'(rd[15:0]), exp);
      kept_addr.push_back(out_off + img_addr_t'(o));
      kept_val.push_back(exp);
    end
  endtask

  task automatic test_fc();
    for (int i = 0; i < 5; i++) begin
      rng = xorshift32(rng);
      in_vec[i] = img_word_t'(rng[6:0]) - img_word_t'(64);
    end
    for (int j = 0; j < 15; j++) begin
      rng = xorshift32(rng);
      wt[j] = weight_t'(rng[7:0]);
    end
    run_fc(200, 300, 40, 3, 5);
  endtask

  task automatic test_clamp();
    logic [31:0] rd;
    for (int i = 0; i < 5; i++) begin
      in_vec[i] = 100;
      wt[i]     = -100;
      wt[5 + i] = 100;
    end
    run_fc(210, 310, 100, 2, 5);
    wb_read(img_adr(310), rd);
    check_img("negative sum", img_word_t'(rd[15:0]), img_word_t'(0));
    wb_read(img_adr(311), rd);
    check_img("overflowing sum", img_word_t'(rd[15:0]), img_word_t'(16'h7fff));
  endtask

  task automatic test_restart();
    logic [31:0] rd;
    for (int i = 0; i < 4; i++) begin
      rng = xorshift32(rng);
      in_vec[i] = img_word_t'(rng[6:0]) - img_word_t'(64);
    end
    for (int j = 0; j < 12; j++) begin
      rng = xorshift32(rng);
      wt[j] = weight_t'(rng[7:0]);
    end
    run_fc(220, 320, 200, 3, 4);
    // Earlier results must survive the second run
    for (int k = 0; k < kept_addr.size(); k++) begin
      wb_read(img_adr(kept_addr[k]), rd);
      check_img($sformatf("kept output at %0d", kept_addr[k]), img_word_t'(rd[15:0]),
                kept_val[k]);
    end
  endtask

  initial begin
    clk      = 1'b0;
    xrst     = 1'b0;
    wb_req   = '0;
    rng      = 32'h0f5f5a6c;
    n_checks = 0;
    n_errors = 0;
    cycle    = 0;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    xrst = 1'b1;
    test_registers();
    test_image();
    test_ownership();
    test_fc();
    test_clamp();
    test_restart();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+include
verilog/ninjin_pkg.sv
verilog/mem_sp.sv
verilog/ninjin_ctrl.sv
verilog/gobou_fc.sv
verilog/kinpira_top.sv
verif/tb_kinpira.sv

/* Bender.yml */
package:
  name: kinpira

export_include_dirs:
  - include

sources:
  - files:
      - verilog/ninjin_pkg.sv
      - verilog/mem_sp.sv
      - verilog/ninjin_ctrl.sv
      - verilog/gobou_fc.sv
      - verilog/kinpira_top.sv
  - target: test
    files:
      - verif/tb_kinpira.sv
